/* Bender.yml */
package:
  name: wfd_core

sources:
  - include_dirs:
      - common
    files:
      - common/wfd_stream_pkg.sv
      - common/wfd_daq_pkg.sv
      - src/stream_fifo.sv
      - src/channel_triggers.sv
      - event_builder/event_builder.sv
      - src/daq_link_tx.sv
      - src/wfd_core.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/wfd_core_tb.sv

/* common/wfd_daq_pkg.sv */
`default_nettype none

`include "wfd_defs.svh"

package wfd_daq_pkg;

    // one word on the DAQ link event port
    typedef struct packed {
        logic [`WFD_DAQ_DATA_W-1:0] data;
        logic                       header;  // first word of an event
        logic                       trailer; // last word of an event
    } daq_word_t;

    // header, timestamp and trailer
    localparam int WFD_EVT_WORDS = 3;

    // Header:    marker [63:56], event number [55:32], zero [31:0]
    // Timestamp: 64-bit clk125 count at the trigger strobe
    // Trailer:   marker [63:56], event number [55:32], word count [31:0]

endpackage

`default_nettype wire

/* common/wfd_defs.svh */
`ifndef WFD_DEFS_SVH
`define WFD_DEFS_SVH

// loopback stream widths
`define WFD_AXIS_DATA_W 32
`define WFD_AXIS_SIDE_W 4 // tkeep, tid and tdest

// buffer depths in entries
`define WFD_LOOP_DEPTH 16
`define WFD_DAQ_DEPTH 16

// DAQ link event word
`define WFD_DAQ_DATA_W 64
`define WFD_EVT_MARKER 8'h5A // bits 63:56 of header and trailer
`define WFD_EVNUM_W 24

// channel trigger outputs
`define WFD_NUM_CHAN 5
`define WFD_TRIG_WIDTH 4 // acquisition pulse length in clk125 cycles

`endif

/* common/wfd_stream_pkg.sv */
`default_nettype none

`include "wfd_defs.svh"

package wfd_stream_pkg;

    // one beat of the control link loopback stream
    typedef struct packed {
        logic [`WFD_AXIS_DATA_W-1:0] tdata;
        logic [`WFD_AXIS_SIDE_W-1:0] tkeep; // byte enables
        logic                        tlast; // end of packet
        logic [`WFD_AXIS_SIDE_W-1:0] tid;
        logic [`WFD_AXIS_SIDE_W-1:0] tdest;
    } axis_beat_t;

    // 32 + 4 + 1 + 4 + 4 bits
    localparam int AXIS_BEAT_W = $bits(axis_beat_t);

endpackage

`default_nettype wire

/* event_builder/event_builder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "wfd_defs.svh"

module event_builder (
    input  wire                                     clk125,
    input  wire                                     rst_n,
    input  wire                                     trigger_in,
    input  wire  [$clog2(`WFD_DAQ_DEPTH + 1)-1:0]   fifo_count,
    output logic                                    trig_accept,
    output logic                                    wr_valid,
    output wfd_daq_pkg::daq_word_t                  wr_data,
    output logic [15:0]                             dropped_count
);

    import wfd_daq_pkg::*;

    localparam int ROOM_MAX = `WFD_DAQ_DEPTH - WFD_EVT_WORDS;
    // extra busy cycles so acceptance stays closed until the pulse ends
    localparam int HOLD_CYC = (`WFD_TRIG_WIDTH > WFD_EVT_WORDS + 1) ?
                              (`WFD_TRIG_WIDTH - WFD_EVT_WORDS - 1) : 0;
    localparam int HOLD_W   = $clog2(`WFD_TRIG_WIDTH + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR,  // header word on wr_data
        S_TS,   // timestamp word on wr_data
        S_TRL,  // trailer word on wr_data
        S_HOLD
    } state_t;

    state_t                     state;
    logic [HOLD_W-1:0]          hold_cnt;
    logic [`WFD_DAQ_DATA_W-1:0] ts_cnt;
    logic [`WFD_DAQ_DATA_W-1:0] ts_q;    // counter value at the strobe edge
    logic [`WFD_DAQ_DATA_W-1:0] evt_ts;
    logic [`WFD_EVNUM_W-1:0]    evnum;
    logic                       trig_q;
    logic                       room;
    logic                       accept;

    assign room   = (int'(fifo_count) <= ROOM_MAX);
    assign accept = trig_q && (state == S_IDLE) && room;

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            ts_cnt <= '0;
            trig_q <= 1'b0;
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
            trig_q <= trigger_in;
        end
    end

    always_ff @(posedge clk125) begin
        ts_q <= ts_cnt;
        if (accept) begin
            evt_ts <= ts_q;
        end
    end

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            hold_cnt      <= '0;
            evnum         <= `WFD_EVNUM_W'(1);
            trig_accept   <= 1'b0;
            wr_valid      <= 1'b0;
            dropped_count <= '0;
        end else begin
            trig_accept <= accept;
            if (trig_q && !accept && dropped_count != '1) begin
                dropped_count <= dropped_count + 1'b1; // saturates
            end
            case (state)
                S_IDLE: begin
                    wr_valid <= accept;
                    if (accept) begin
                        wr_data <= '{data: {`WFD_EVT_MARKER, evnum, 32'd0},
                                     header: 1'b1, trailer: 1'b0};
                        state   <= S_HDR;
                    end
                end
                S_HDR: begin
                    wr_data <= '{data: evt_ts, header: 1'b0, trailer: 1'b0};
                    state   <= S_TS;
                end
                S_TS: begin
                    wr_data <= '{data: {`WFD_EVT_MARKER, evnum, 32'(WFD_EVT_WORDS)},
                                 header: 1'b0, trailer: 1'b1};
                    state   <= S_TRL;
                end
                S_TRL: begin
                    wr_valid <= 1'b0;
                    evnum    <= evnum + 1'b1;
                    hold_cnt <= HOLD_W'(HOLD_CYC);
                    state    <= (HOLD_CYC > 0) ? S_HOLD : S_IDLE;
                end
                S_HOLD: begin
                    hold_cnt <= hold_cnt - 1'b1;
                    if (hold_cnt <= HOLD_W'(1)) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    wr_valid <= 1'b0;
                    state    <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/wfd_stream_pkg.sv
common/wfd_daq_pkg.sv
src/stream_fifo.sv
src/channel_triggers.sv
event_builder/event_builder.sv
src/daq_link_tx.sv
src/wfd_core.sv
verification/wfd_core_tb.sv

/* src/channel_triggers.sv */
`timescale 1ns/10ps
`default_nettype none

`include "wfd_defs.svh"

module channel_triggers (
    input  wire                         clk125,
    input  wire                         rst_n,
    input  wire                         trig_accept,
    input  wire  [`WFD_NUM_CHAN-1:0]    chan_enable,
    output logic [`WFD_NUM_CHAN-1:0]    acq_trigs
);

    localparam int CNT_W = $clog2(`WFD_TRIG_WIDTH + 1);

    logic [CNT_W-1:0]         remain; // pulse cycles left after the first
    logic [`WFD_NUM_CHAN-1:0] mask_q;
    logic                     start;

    // ignored while a pulse is still running
    assign start = trig_accept && (remain == '0);

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            remain <= '0;
            mask_q <= '0;
        end else if (start) begin
            remain <= CNT_W'(`WFD_TRIG_WIDTH - 1);
            mask_q <= chan_enable; // held for the rest of the pulse
        end else if (remain != '0) begin
            remain <= remain - 1'b1;
        end
    end

    // first pulse cycle comes straight from trig_accept, the rest from the latch
    always_comb begin
        if (start) begin
            acq_trigs = chan_enable;
        end else if (remain != '0) begin
            acq_trigs = mask_q;
        end else begin
            acq_trigs = '0;
        end
    end

endmodule

`default_nettype wire

/* src/daq_link_tx.sv */
`timescale 1ns/10ps
`default_nettype none

`include "wfd_defs.svh"

module daq_link_tx (
    input  wire                             clk125,
    input  wire                             rst_n,
    input  wire                             rd_valid,
    output logic                            rd_ready,
    input  wire wfd_daq_pkg::daq_word_t     rd_data,
    input  wire                             daq_ready,
    input  wire                             daq_almost_full,
    output logic                            daq_valid,
    output logic                            daq_header,
    output logic                            daq_trailer,
    output logic [`WFD_DAQ_DATA_W-1:0]      daq_data
);

    logic pop;

    // link must be up and not close to full
    assign rd_ready = daq_ready && !daq_almost_full;
    assign pop      = rd_valid && rd_ready;

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            daq_valid   <= 1'b0;
            daq_header  <= 1'b0;
            daq_trailer <= 1'b0;
        end else begin
            daq_valid   <= pop; // one cycle per word
            daq_header  <= pop && rd_data.header;
            daq_trailer <= pop && rd_data.trailer;
        end
    end

    always_ff @(posedge clk125) begin
        if (pop) begin
            daq_data <= rd_data.data;
        end
    end

endmodule

`default_nettype wire

/* src/stream_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  wire                              clk125,
    input  wire                              rst_n,
    input  wire                              in_valid,
    output logic                             in_ready,
    input  wire payload_t                    in_data,
    output logic                             out_valid,
    input  wire                              out_ready,
    output payload_t                         out_data,
    output logic [$clog2(DEPTH + 1)-1:0]     count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH)); // no space when full
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // head entry straight from the storage flops
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk125) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle, or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/wfd_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "wfd_defs.svh"

module wfd_core (
    input  wire                             clk125,
    input  wire                             rst_n,

    input  wire                             trigger_in,
    input  wire  [`WFD_NUM_CHAN-1:0]        chan_enable,
    output logic [`WFD_NUM_CHAN-1:0]        acq_trigs,
    output logic [15:0]                     dropped_count,

    input  wire                             axis_in_tvalid,
    output logic                            axis_in_tready,
    input  wire  [`WFD_AXIS_DATA_W-1:0]     axis_in_tdata,
    input  wire  [`WFD_AXIS_SIDE_W-1:0]     axis_in_tkeep,
    input  wire                             axis_in_tlast,
    input  wire  [`WFD_AXIS_SIDE_W-1:0]     axis_in_tid,
    input  wire  [`WFD_AXIS_SIDE_W-1:0]     axis_in_tdest,

    output logic                            axis_out_tvalid,
    input  wire                             axis_out_tready,
    output logic [`WFD_AXIS_DATA_W-1:0]     axis_out_tdata,
    output logic [`WFD_AXIS_SIDE_W-1:0]     axis_out_tkeep,
    output logic                            axis_out_tlast,
    output logic [`WFD_AXIS_SIDE_W-1:0]     axis_out_tid,
    output logic [`WFD_AXIS_SIDE_W-1:0]     axis_out_tdest,

    output logic                            daq_valid,
    output logic                            daq_header,
    output logic                            daq_trailer,
    output logic [`WFD_DAQ_DATA_W-1:0]      daq_data,
    input  wire                             daq_ready,
    input  wire                             daq_almost_full
);

    import wfd_stream_pkg::*;
    import wfd_daq_pkg::*;

    axis_beat_t                                 loop_in;
    axis_beat_t                                 loop_out;
    logic                                       trig_accept;
    logic                                       evt_wr_valid;
    daq_word_t                                  evt_wr_data;
    logic [$clog2(`WFD_DAQ_DEPTH + 1)-1:0]      evt_count;
    logic                                       evt_rd_valid;
    logic                                       evt_rd_ready;
    daq_word_t                                  evt_rd_data;

    // control link loopback
    assign loop_in.tdata = axis_in_tdata;
    assign loop_in.tkeep = axis_in_tkeep;
    assign loop_in.tlast = axis_in_tlast;
    assign loop_in.tid   = axis_in_tid;
    assign loop_in.tdest = axis_in_tdest;

    assign axis_out_tdata = loop_out.tdata;
    assign axis_out_tkeep = loop_out.tkeep;
    assign axis_out_tlast = loop_out.tlast;
    assign axis_out_tid   = loop_out.tid;
    assign axis_out_tdest = loop_out.tdest;

    stream_fifo #(
        .payload_t (axis_beat_t),
        .DEPTH     (`WFD_LOOP_DEPTH)
    ) u_loop_fifo (
        .clk125    (clk125),
        .rst_n     (rst_n),
        .in_valid  (axis_in_tvalid),
        .in_ready  (axis_in_tready),
        .in_data   (loop_in),
        .out_valid (axis_out_tvalid),
        .out_ready (axis_out_tready),
        .out_data  (loop_out),
        .count     ()
    );

    event_builder u_event_builder (
        .clk125        (clk125),
        .rst_n         (rst_n),
        .trigger_in    (trigger_in),
        .fifo_count    (evt_count),
        .trig_accept   (trig_accept),
        .wr_valid      (evt_wr_valid),
        .wr_data       (evt_wr_data),
        .dropped_count (dropped_count)
    );

    // builder checks free space first, so in_ready is not needed
    stream_fifo #(
        .payload_t (daq_word_t),
        .DEPTH     (`WFD_DAQ_DEPTH)
    ) u_evt_fifo (
        .clk125    (clk125),
        .rst_n     (rst_n),
        .in_valid  (evt_wr_valid),
        .in_ready  (),
        .in_data   (evt_wr_data),
        .out_valid (evt_rd_valid),
        .out_ready (evt_rd_ready),
        .out_data  (evt_rd_data),
        .count     (evt_count)
    );

    daq_link_tx u_daq_link_tx (
        .clk125          (clk125),
        .rst_n           (rst_n),
        .rd_valid        (evt_rd_valid),
        .rd_ready        (evt_rd_ready),
        .rd_data         (evt_rd_data),
        .daq_ready       (daq_ready),
        .daq_almost_full (daq_almost_full),
        .daq_valid       (daq_valid),
        .daq_header      (daq_header),
        .daq_trailer     (daq_trailer),
        .daq_data        (daq_data)
    );

    channel_triggers u_channel_triggers (
        .clk125      (clk125),
        .rst_n       (rst_n),
        .trig_accept (trig_accept),
        .chan_enable (chan_enable),
        .acq_trigs   (acq_trigs)
    );

endmodule

`default_nettype wire

/* verification/wfd_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "wfd_defs.svh"

module wfd_core_tb;

    localparam int TEST_CYC    = 2 + 300 + 40 + 60 + 120 + 80; // rough length of all tests
    localparam int TIMEOUT_CYC = 2 * TEST_CYC;
    localparam int BEAT_W      = `WFD_AXIS_DATA_W + 3 * `WFD_AXIS_SIDE_W + 1;

    logic                         clk125;
    logic                         rst_n;
    logic                         trigger_in;
    logic [`WFD_NUM_CHAN-1:0]     chan_enable;
    logic [`WFD_NUM_CHAN-1:0]     acq_trigs;
    logic [15:0]                  dropped_count;
    logic                         axis_in_tvalid;
    logic                         axis_in_tready;
    logic [`WFD_AXIS_DATA_W-1:0]  axis_in_tdata;
    logic [`WFD_AXIS_SIDE_W-1:0]  axis_in_tkeep;
    logic                         axis_in_tlast;
    logic [`WFD_AXIS_SIDE_W-1:0]  axis_in_tid;
    logic [`WFD_AXIS_SIDE_W-1:0]  axis_in_tdest;
    logic                         axis_out_tvalid;
    logic                         axis_out_tready;
    logic [`WFD_AXIS_DATA_W-1:0]  axis_out_tdata;
    logic [`WFD_AXIS_SIDE_W-1:0]  axis_out_tkeep;
    logic                         axis_out_tlast;
    logic [`WFD_AXIS_SIDE_W-1:0]  axis_out_tid;
    logic [`WFD_AXIS_SIDE_W-1:0]  axis_out_tdest;
    logic                         daq_valid;
    logic                         daq_header;
    logic                         daq_trailer;
    logic [`WFD_DAQ_DATA_W-1:0]   daq_data;
    logic                         daq_ready;
    logic                         daq_almost_full;

    int                           errors = 0;
    int                           checks = 0;
    int                           run_cyc = 0;
    int                           loop_level = 0; // beats held in the loopback FIFO
    logic [63:0]                  cyc; // timestamp model
    logic [23:0]                  exp_evnum = 24'd1;
    logic [31:0]                  lfsr_state = 32'h8559;
    logic [65:0]                  daq_got [$]; // {header, trailer, data}
    logic [BEAT_W-1:0]            loop_got [$];
    logic [BEAT_W-1:0]            out_beat;
    logic [BEAT_W-1:0]            held_beat;
    logic                         out_stalled = 1'b0;

    wfd_core u_dut (.*);

    assign out_beat = {axis_out_tdata, axis_out_tkeep, axis_out_tlast, axis_out_tid,
                       axis_out_tdest};

    initial begin
        clk125 = 1'b0;
        forever #50 clk125 = ~clk125;
    end

    always @(posedge clk125) begin
        if (!rst_n)
            cyc <= '0;
        else
            cyc <= cyc + 1; // zero on the first edge out of reset
    end

    always @(posedge clk125) begin
        run_cyc <= run_cyc + 1;
        if (run_cyc >= TIMEOUT_CYC) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    always @(negedge clk125) begin
        if (rst_n && daq_valid)
            daq_got.push_back({daq_header, daq_trailer, daq_data});
    end

    // a stalled output beat must stay put until taken
    always @(negedge clk125) begin
        if (rst_n) begin
            check("loopback tready", loop_level != `WFD_LOOP_DEPTH, axis_in_tready);
            check("loopback tvalid", loop_level != 0, axis_out_tvalid);
            if (out_stalled)
                check("loopback hold", {1'b1, held_beat}, {axis_out_tvalid, out_beat});
            out_stalled = axis_out_tvalid && !axis_out_tready;
            held_beat   = out_beat;
            if (axis_out_tvalid && axis_out_tready)
                loop_got.push_back(out_beat);
            // occupancy after the coming edge
            if (axis_in_tvalid && axis_in_tready)
                loop_level++;
            if (axis_out_tvalid && axis_out_tready)
                loop_level--;
        end
    end

    task automatic check(input string name, input logic [65:0] exp, input logic [65:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic drive_beat(input logic [BEAT_W-1:0] beat);
        axis_in_tdata <= beat[BEAT_W-1 -: `WFD_AXIS_DATA_W];
        axis_in_tkeep <= beat[12:9];
        axis_in_tlast <= beat[8];
        axis_in_tid   <= beat[7:4];
        axis_in_tdest <= beat[3:0];
    endtask

    // returns right after the edge that samples the strobe
    task automatic pulse_trigger(output logic [63:0] ts);
        @(posedge clk125);
        trigger_in <= 1'b1;
        ts = cyc + 1;
        @(posedge clk125);
        trigger_in <= 1'b0;
    endtask

    task automatic wait_daq(input int n);
        int t;
        t = 0;
        while (daq_got.size() < n && t < 100) begin
            @(posedge clk125);
            t++;
        end
        if (daq_got.size() < n) begin
            errors++;
            $display("Error: only %0d of %0d DAQ words arrived in time", daq_got.size(), n);
        end
    endtask

    task automatic check_event(input string name, input int base, input logic [23:0] evn,
                               input logic [63:0] ts);
        check({name, " header"}, {2'b10, `WFD_EVT_MARKER, evn, 32'd0}, daq_got[base]);
        check({name, " timestamp"}, {2'b00, ts}, daq_got[base + 1]);
        check({name, " trailer"}, {2'b01, `WFD_EVT_MARKER, evn, 32'd3}, daq_got[base + 2]);
    endtask

    task automatic reset_test();
        @(negedge clk125);
        check("reset daq_valid", 0, {daq_valid, daq_header, daq_trailer});
        check("reset acq_trigs", 0, acq_trigs);
        check("reset axis_out_tvalid", 0, axis_out_tvalid);
        check("reset dropped_count", 0, dropped_count);
    endtask

    task automatic loopback_test();
        logic [BEAT_W-1:0] sent [$];
        logic [BEAT_W-1:0] beat;
        logic              acc;
        int                n;
        int                t;
        n = 0;
        t = 0;
        @(posedge clk125);
        beat = rand_bits(BEAT_W);
        drive_beat(beat);
        axis_in_tvalid <= 1'b1;
        while (n < 40) begin
            @(negedge clk125);
            acc = axis_in_tready;
            @(posedge clk125);
            axis_out_tready <= (rand_bits(2) == 2'b11); // slow drain fills the FIFO
            if (acc) begin
                sent.push_back(beat);
                n++;
                if (n < 40) begin
                    beat = rand_bits(BEAT_W);
                    drive_beat(beat);
                end else begin
                    axis_in_tvalid <= 1'b0;
                end
            end
        end
        axis_out_tready <= 1'b1;
        while (loop_got.size() < 40 && t < 100) begin
            @(posedge clk125);
            t++;
        end
        check("loopback beat count", 40, loop_got.size());
        for (n = 0; n < 40; n++)
            check("loopback beat", sent[n], loop_got[n]);
    endtask

    task automatic single_trigger_test();
        logic [63:0] ts;
        int          i;
        daq_got.delete();
        @(posedge clk125);
        chan_enable <= 5'b10110;
        pulse_trigger(ts);
        @(negedge clk125);
        check("pulse not yet started", 0, acq_trigs);
        for (i = 0; i < `WFD_TRIG_WIDTH; i++) begin
            @(negedge clk125);
            check("pulse active", 5'b10110, acq_trigs);
        end
        @(negedge clk125);
        check("pulse ended", 0, acq_trigs);
        wait_daq(3);
        check_event("single trigger", 0, exp_evnum, ts);
        exp_evnum++;
        repeat (10) @(posedge clk125);
    endtask

    task automatic double_trigger_test();
        logic [63:0] ts;
        logic [15:0] drops;
        daq_got.delete();
        drops = dropped_count;
        pulse_trigger(ts);
        @(posedge clk125);
        trigger_in <= 1'b1; // lands while the builder is busy
        @(posedge clk125);
        trigger_in <= 1'b0;
        wait_daq(3);
        repeat (20) @(posedge clk125);
        check("double trigger word count", 3, daq_got.size());
        check_event("double trigger", 0, exp_evnum, ts);
        exp_evnum++;
        check("double trigger drops", drops + 1, dropped_count);
    endtask

    task automatic backpressure_test();
        logic [63:0] ts [6];
        logic [15:0] drops;
        int          i;
        daq_got.delete();
        drops = dropped_count;
        @(posedge clk125);
        daq_almost_full <= 1'b1;
        for (i = 0; i < 6; i++) begin
            pulse_trigger(ts[i]);
            repeat (7) @(posedge clk125);
        end
        check("almost full blocks output", 0, daq_got.size());
        check("sixth trigger dropped", drops + 1, dropped_count);
        @(posedge clk125);
        daq_almost_full <= 1'b0;
        wait_daq(15);
        for (i = 0; i < 5; i++)
            check_event("backpressure event", i * 3, exp_evnum + i, ts[i]);
        exp_evnum += 5;
        repeat (10) @(posedge clk125);
        check("backpressure word count", 15, daq_got.size());
    endtask

    task automatic ready_low_test();
        logic [63:0] ts [2];
        int          i;
        daq_got.delete();
        @(posedge clk125);
        daq_ready <= 1'b0;
        for (i = 0; i < 2; i++) begin
            pulse_trigger(ts[i]);
            repeat (7) @(posedge clk125);
        end
        repeat (15) @(posedge clk125);
        check("ready low blocks output", 0, daq_got.size());
        daq_ready <= 1'b1;
        wait_daq(6);
        for (i = 0; i < 2; i++)
            check_event("ready low event", i * 3, exp_evnum + i, ts[i]);
        exp_evnum += 2;
        repeat (10) @(posedge clk125);
    endtask

    initial begin
        rst_n           = 1'b0;
        trigger_in      = 1'b0;
        chan_enable     = '0;
        axis_in_tvalid  = 1'b0;
        axis_in_tdata   = '0;
        axis_in_tkeep   = '0;
        axis_in_tlast   = 1'b0;
        axis_in_tid     = '0;
        axis_in_tdest   = '0;
        axis_out_tready = 1'b0;
        daq_ready       = 1'b1;
        daq_almost_full = 1'b0;
        repeat (2) @(posedge clk125);
        rst_n <= 1'b1;
        reset_test();
        loopback_test();
        single_trigger_test();
        double_trigger_test();
        backpressure_test();
        ready_low_test();
        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
